/* island_pkg.sv */
// Shared bus widths, address map and error codes of the security island

package island_pkg;

   //////////////////////////////////////////////////////////////////////
   // Bus widths
   //////////////////////////////////////////////////////////////////////

   localparam int unsigned AddrWidth     = 32;
   localparam int unsigned DataWidth     = 32;
   localparam int unsigned NumInitiators = 2;
   localparam int unsigned SrcWidth      = 1;

   //////////////////////////////////////////////////////////////////////
   // Address map
   //////////////////////////////////////////////////////////////////////

   // Start inclusive, end exclusive
   localparam logic [AddrWidth-1:0] HostBase = 32'h0001_0000;
   localparam logic [AddrWidth-1:0] HostEnd  = 32'hA000_0000;
   localparam logic [AddrWidth-1:0] ClsBase  = 32'hA100_0000;
   localparam logic [AddrWidth-1:0] ClsEnd   = 32'hB000_0000;

   //////////////////////////////////////////////////////////////////////
   // Error reporting
   //////////////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      ErrNone     = 2'd0,
      ErrDecode   = 2'd1,
      ErrIsolated = 2'd2
   } err_code_e;

endpackage

/* req_arbiter.sv */
// Round-robin arbiter of the bridge and DMA requests into a one-entry slice

`timescale 1ns/1ps

module req_arbiter (
   input  logic                                                    clk_i,
   input  logic                                                    arst_n_i,
   input  logic [island_pkg::NumInitiators-1:0]                    req_valid_i,
   output logic [island_pkg::NumInitiators-1:0]                    req_ready_o,
   input  logic [island_pkg::NumInitiators-1:0][island_pkg::AddrWidth-1:0] req_addr_i,
   input  logic [island_pkg::NumInitiators-1:0][island_pkg::DataWidth-1:0] req_wdata_i,
   input  logic [island_pkg::NumInitiators-1:0]                    req_we_i,
   output logic                                                    arb_valid_o,
   input  logic                                                    arb_ready_i,
   output logic [island_pkg::AddrWidth-1:0]                        arb_addr_o,
   output logic [island_pkg::DataWidth-1:0]                        arb_wdata_o,
   output logic                                                    arb_we_o,
   output logic [island_pkg::SrcWidth-1:0]                         arb_src_o
);

   logic                            rr_q;
   logic                            both_req;
   logic                            slice_free;
   logic [island_pkg::SrcWidth-1:0] gnt_idx;
   logic                            valid_q;

   assign both_req   = req_valid_i[0] & req_valid_i[1];

   // Slice takes a new item while the held one leaves
   assign slice_free = ~valid_q | arb_ready_i;

   always_comb begin
      if (both_req) begin
         gnt_idx = rr_q;
      end else if (req_valid_i[1]) begin
         gnt_idx = 1'b1;
      end else begin
         gnt_idx = 1'b0;
      end
   end

   always_comb begin
      for (int i = 0; i < island_pkg::NumInitiators; i++) begin
         req_ready_o[i] = slice_free && (gnt_idx == island_pkg::SrcWidth'(i));
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Priority pointer and slice control
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rr_q    <= 1'b0;
         valid_q <= 1'b0;
      end else if (slice_free) begin
         valid_q <= |req_valid_i;
         // Flip only on contention
         if (both_req) begin
            rr_q <= ~rr_q;
         end
      end
   end

   // Payload and initiator index
   always_ff @(posedge clk_i) begin
      if (slice_free && (|req_valid_i)) begin
         arb_addr_o  <= req_addr_i[gnt_idx];
         arb_wdata_o <= req_wdata_i[gnt_idx];
         arb_we_o    <= req_we_i[gnt_idx];
         arb_src_o   <= gnt_idx;
      end
   end

   assign arb_valid_o = valid_q;

endmodule

/* addr_router.sv */
// Address decode, isolation gate and error termination toward the two ports

`timescale 1ns/1ps

module addr_router #(
   parameter int unsigned SyncStages = 3
) (
   input  logic                              clk_i,
   input  logic                              arst_n_i,
   input  logic                              arb_valid_i,
   output logic                              arb_ready_o,
   input  logic [island_pkg::AddrWidth-1:0]  arb_addr_i,
   input  logic [island_pkg::DataWidth-1:0]  arb_wdata_i,
   input  logic                              arb_we_i,
   input  logic [island_pkg::SrcWidth-1:0]   arb_src_i,
   output logic                              host_valid_o,
   input  logic                              host_ready_i,
   output logic                              cls_valid_o,
   input  logic                              cls_ready_i,
   output logic [island_pkg::AddrWidth-1:0]  fwd_addr_o,
   output logic [island_pkg::DataWidth-1:0]  fwd_wdata_o,
   output logic                              fwd_we_o,
   output logic [island_pkg::SrcWidth-1:0]   fwd_src_o,
   input  logic                              host_idle_i,
   output logic                              err_valid_o,
   output island_pkg::err_code_e             err_code_o,
   output logic [island_pkg::SrcWidth-1:0]   err_src_o,
   input  logic                              isolate_i,
   output logic                              isolated_o
);

   logic [SyncStages-1:0]  iso_sync_q;
   logic                   iso_sync;

   logic                   host_hit;
   logic                   cls_hit;
   logic                   dec_err;
   island_pkg::err_code_e  dec_code;

   logic                   valid_q;
   logic                   is_err_q;
   logic                   is_host_q;
   island_pkg::err_code_e  code_q;
   logic                   out_done;

   //////////////////////////////////////////////////////////////////////
   // Isolate synchronizer
   //////////////////////////////////////////////////////////////////////

   // Comes out of reset isolated
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         iso_sync_q <= '1;
      end else begin
         iso_sync_q <= {iso_sync_q[SyncStages-2:0], isolate_i};
      end
   end

   assign iso_sync = iso_sync_q[SyncStages-1];

   //////////////////////////////////////////////////////////////////////
   // Decode
   //////////////////////////////////////////////////////////////////////

   assign host_hit = (arb_addr_i >= island_pkg::HostBase) && (arb_addr_i < island_pkg::HostEnd);
   assign cls_hit  = (arb_addr_i >= island_pkg::ClsBase) && (arb_addr_i < island_pkg::ClsEnd);

   always_comb begin
      if (host_hit && iso_sync) begin
         dec_err  = 1'b1;
         dec_code = island_pkg::ErrIsolated;
      end else if (!host_hit && !cls_hit) begin
         dec_err  = 1'b1;
         dec_code = island_pkg::ErrDecode;
      end else begin
         dec_err  = 1'b0;
         dec_code = island_pkg::ErrNone;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Output stage
   //////////////////////////////////////////////////////////////////////

   // Errors drain at once, forwards wait for their port
   assign out_done    = ~valid_q | is_err_q | (is_host_q ? host_ready_i : cls_ready_i);
   assign arb_ready_o = out_done;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         valid_q   <= 1'b0;
         is_err_q  <= 1'b0;
         is_host_q <= 1'b0;
         code_q    <= island_pkg::ErrNone;
      end else if (out_done) begin
         valid_q <= arb_valid_i;
         if (arb_valid_i) begin
            is_err_q  <= dec_err;
            is_host_q <= host_hit;
            code_q    <= dec_code;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (out_done && arb_valid_i) begin
         fwd_addr_o  <= arb_addr_i;
         fwd_wdata_o <= arb_wdata_i;
         fwd_we_o    <= arb_we_i;
         fwd_src_o   <= arb_src_i;
      end
   end

   assign host_valid_o = valid_q & ~is_err_q & is_host_q;
   assign cls_valid_o  = valid_q & ~is_err_q & ~is_host_q;
   assign err_valid_o  = valid_q & is_err_q;
   assign err_code_o   = code_q;
   assign err_src_o    = fwd_src_o;

   // Isolated once nothing host-bound is left in flight
   assign isolated_o = iso_sync & host_idle_i & ~host_valid_o;

endmodule

/* credit_tx.sv */
// Request buffer with credit-based flow control toward one output port

`timescale 1ns/1ps

module credit_tx #(
   parameter int unsigned CreditDepth = 4
) (
   input  logic                              clk_i,
   input  logic                              arst_n_i,
   input  logic                              fwd_valid_i,
   output logic                              fwd_ready_o,
   input  logic [island_pkg::AddrWidth-1:0]  fwd_addr_i,
   input  logic [island_pkg::DataWidth-1:0]  fwd_wdata_i,
   input  logic                              fwd_we_i,
   input  logic [island_pkg::SrcWidth-1:0]   fwd_src_i,
   output logic                              out_valid_o,
   output logic [island_pkg::AddrWidth-1:0]  out_addr_o,
   output logic [island_pkg::DataWidth-1:0]  out_wdata_o,
   output logic                              out_we_o,
   output logic [island_pkg::SrcWidth-1:0]   out_src_o,
   input  logic                              credit_i,
   output logic                              idle_o
);

   localparam int unsigned PtrWidth = (CreditDepth > 1) ? $clog2(CreditDepth) : 1;
   localparam int unsigned CntWidth = $clog2(CreditDepth + 1);
   localparam int unsigned EntWidth = island_pkg::AddrWidth + island_pkg::DataWidth + 1 +
                                      island_pkg::SrcWidth;

   logic [EntWidth-1:0] mem_q [CreditDepth];
   logic [PtrWidth-1:0] wr_ptr_q;
   logic [PtrWidth-1:0] rd_ptr_q;
   logic [CntWidth-1:0] fill_q;
   logic [CntWidth-1:0] credit_q;
   logic                push;
   logic                pop;

   assign fwd_ready_o = (fill_q != CntWidth'(CreditDepth));
   assign push        = fwd_valid_i & fwd_ready_o;

   // Head issues whenever a credit is left
   assign pop         = (fill_q != '0) && (credit_q != '0);
   assign out_valid_o = pop;

   assign {out_addr_o, out_wdata_o, out_we_o, out_src_o} = mem_q[rd_ptr_q];

   always_ff @(posedge clk_i) begin
      if (push) begin
         mem_q[wr_ptr_q] <= {fwd_addr_i, fwd_wdata_i, fwd_we_i, fwd_src_i};
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         fill_q   <= '0;
         credit_q <= CntWidth'(CreditDepth);
      end else begin
         if (push) begin
            wr_ptr_q <= (wr_ptr_q == PtrWidth'(CreditDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= (rd_ptr_q == PtrWidth'(CreditDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         fill_q   <= fill_q + CntWidth'(push) - CntWidth'(pop);
         credit_q <= credit_q + CntWidth'(credit_i) - CntWidth'(pop);
      end
   end

   // All credits back and nothing queued
   assign idle_o = (credit_q == CntWidth'(CreditDepth)) && (fill_q == '0);

endmodule

/* security_island.sv */
// Request-routing core of the secure subsystem with host and cluster ports

`timescale 1ns/1ps

module security_island #(
   parameter int unsigned CreditDepth = 4,
   parameter int unsigned SyncStages  = 3
) (
   input  logic                                                    clk_i,
   input  logic                                                    arst_n_i,
   // Initiators
   input  logic [island_pkg::NumInitiators-1:0]                    req_valid_i,
   output logic [island_pkg::NumInitiators-1:0]                    req_ready_o,
   input  logic [island_pkg::NumInitiators-1:0][island_pkg::AddrWidth-1:0] req_addr_i,
   input  logic [island_pkg::NumInitiators-1:0][island_pkg::DataWidth-1:0] req_wdata_i,
   input  logic [island_pkg::NumInitiators-1:0]                    req_we_i,
   // Host port
   output logic                                                    host_valid_o,
   output logic [island_pkg::AddrWidth-1:0]                        host_addr_o,
   output logic [island_pkg::DataWidth-1:0]                        host_wdata_o,
   output logic                                                    host_we_o,
   output logic [island_pkg::SrcWidth-1:0]                         host_src_o,
   input  logic                                                    host_credit_i,
   // Cluster port
   output logic                                                    cls_valid_o,
   output logic [island_pkg::AddrWidth-1:0]                        cls_addr_o,
   output logic [island_pkg::DataWidth-1:0]                        cls_wdata_o,
   output logic                                                    cls_we_o,
   output logic [island_pkg::SrcWidth-1:0]                         cls_src_o,
   input  logic                                                    cls_credit_i,
   // Errors and isolation
   output logic                                                    err_valid_o,
   output island_pkg::err_code_e                                   err_code_o,
   output logic [island_pkg::SrcWidth-1:0]                         err_src_o,
   input  logic                                                    isolate_i,
   output logic                                                    isolated_o
);

   logic                             arb_valid;
   logic                             arb_ready;
   logic [island_pkg::AddrWidth-1:0] arb_addr;
   logic [island_pkg::DataWidth-1:0] arb_wdata;
   logic                             arb_we;
   logic [island_pkg::SrcWidth-1:0]  arb_src;

   logic                             host_fwd_valid;
   logic                             host_fwd_ready;
   logic                             cls_fwd_valid;
   logic                             cls_fwd_ready;
   logic [island_pkg::AddrWidth-1:0] fwd_addr;
   logic [island_pkg::DataWidth-1:0] fwd_wdata;
   logic                             fwd_we;
   logic [island_pkg::SrcWidth-1:0]  fwd_src;
   logic                             host_idle;

   req_arbiter u_arbiter (
      .clk_i       ( clk_i       ),
      .arst_n_i    ( arst_n_i    ),
      .req_valid_i ( req_valid_i ),
      .req_ready_o ( req_ready_o ),
      .req_addr_i  ( req_addr_i  ),
      .req_wdata_i ( req_wdata_i ),
      .req_we_i    ( req_we_i    ),
      .arb_valid_o ( arb_valid   ),
      .arb_ready_i ( arb_ready   ),
      .arb_addr_o  ( arb_addr    ),
      .arb_wdata_o ( arb_wdata   ),
      .arb_we_o    ( arb_we      ),
      .arb_src_o   ( arb_src     )
   );

   addr_router #(
      .SyncStages ( SyncStages )
   ) u_router (
      .clk_i        ( clk_i          ),
      .arst_n_i     ( arst_n_i       ),
      .arb_valid_i  ( arb_valid      ),
      .arb_ready_o  ( arb_ready      ),
      .arb_addr_i   ( arb_addr       ),
      .arb_wdata_i  ( arb_wdata      ),
      .arb_we_i     ( arb_we         ),
      .arb_src_i    ( arb_src        ),
      .host_valid_o ( host_fwd_valid ),
      .host_ready_i ( host_fwd_ready ),
      .cls_valid_o  ( cls_fwd_valid  ),
      .cls_ready_i  ( cls_fwd_ready  ),
      .fwd_addr_o   ( fwd_addr       ),
      .fwd_wdata_o  ( fwd_wdata      ),
      .fwd_we_o     ( fwd_we         ),
      .fwd_src_o    ( fwd_src        ),
      .host_idle_i  ( host_idle      ),
      .err_valid_o  ( err_valid_o    ),
      .err_code_o   ( err_code_o     ),
      .err_src_o    ( err_src_o      ),
      .isolate_i    ( isolate_i      ),
      .isolated_o   ( isolated_o     )
   );

   credit_tx #(
      .CreditDepth ( CreditDepth )
   ) u_host_tx (
      .clk_i       ( clk_i          ),
      .arst_n_i    ( arst_n_i       ),
      .fwd_valid_i ( host_fwd_valid ),
      .fwd_ready_o ( host_fwd_ready ),
      .fwd_addr_i  ( fwd_addr       ),
      .fwd_wdata_i ( fwd_wdata      ),
      .fwd_we_i    ( fwd_we         ),
      .fwd_src_i   ( fwd_src        ),
      .out_valid_o ( host_valid_o   ),
      .out_addr_o  ( host_addr_o    ),
      .out_wdata_o ( host_wdata_o   ),
      .out_we_o    ( host_we_o      ),
      .out_src_o   ( host_src_o     ),
      .credit_i    ( host_credit_i  ),
      .idle_o      ( host_idle      )
   );

   // Cluster side never isolates, so its idle flag stays open
   credit_tx #(
      .CreditDepth ( CreditDepth )
   ) u_cls_tx (
      .clk_i       ( clk_i         ),
      .arst_n_i    ( arst_n_i      ),
      .fwd_valid_i ( cls_fwd_valid ),
      .fwd_ready_o ( cls_fwd_ready ),
      .fwd_addr_i  ( fwd_addr      ),
      .fwd_wdata_i ( fwd_wdata     ),
      .fwd_we_i    ( fwd_we        ),
      .fwd_src_i   ( fwd_src       ),
      .out_valid_o ( cls_valid_o   ),
      .out_addr_o  ( cls_addr_o    ),
      .out_wdata_o ( cls_wdata_o   ),
      .out_we_o    ( cls_we_o      ),
      .out_src_o   ( cls_src_o     ),
      .credit_i    ( cls_credit_i  ),
      .idle_o      (               )
   );

endmodule

/* security_island_asserts.sv */
// Protocol assertions on the security island ports

`timescale 1ns/1ps

module security_island_asserts (
   input logic                                                    clk_i,
   input logic                                                    arst_n_i,
   input logic [island_pkg::NumInitiators-1:0]                    req_valid_i,
   input logic [island_pkg::NumInitiators-1:0]                    req_ready_o,
   input logic [island_pkg::NumInitiators-1:0][island_pkg::AddrWidth-1:0] req_addr_i,
   input logic                                                    host_valid_o,
   input logic                                                    err_valid_o,
   input logic [1:0]                                              err_code_o,
   input logic                                                    isolated_o
);

   // Count of failed assertions
   int assert_failures = 0;

   // Host port stays silent while isolated
   host_quiet_isolated: assert property (
      @(posedge clk_i) disable iff (!arst_n_i) isolated_o |-> !host_valid_o
   ) else begin
      $error("host_valid_o high while isolated_o is high");
      assert_failures++;
   end

   // Every error pulse carries a real cause
   err_code_known: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      err_valid_o |-> (err_code_o == island_pkg::ErrDecode) ||
                      (err_code_o == island_pkg::ErrIsolated)
   ) else begin
      $error("err_valid_o with code %0d", err_code_o);
      assert_failures++;
   end

   for (genvar n = 0; n < island_pkg::NumInitiators; n++) begin : g_req_hold
      req_held: assert property (
         @(posedge clk_i) disable iff (!arst_n_i)
         (req_valid_i[n] && !req_ready_o[n]) |=> (req_valid_i[n] && $stable(req_addr_i[n]))
      ) else begin
         $error("req_valid_i[%0d] dropped or changed before its transfer", n);
         assert_failures++;
      end
   end

endmodule

/* tb_security_island.sv */
// Testbench of the security island with seeded random traffic and a queue model

`timescale 1ns/1ps

module tb_security_island;

   localparam int unsigned CreditDepth   = 4;
   localparam int unsigned SyncStages    = 3;
   localparam int          NumRequests   = 2 * (60 + 20 + 12 + 30 + 20);
   localparam int          TimeoutCycles = NumRequests * 4 * CreditDepth + 2000;

   // Address map, start inclusive and end exclusive
   localparam logic [31:0] HostLo = 32'h0001_0000;
   localparam logic [31:0] HostHi = 32'hA000_0000;
   localparam logic [31:0] ClsLo  = 32'hA100_0000;
   localparam logic [31:0] ClsHi  = 32'hB000_0000;

   // Regions: host, cluster, gap, below host, above cluster
   localparam logic [31:0] RegionBase [5] = '{HostLo, ClsLo, HostHi, 32'h0, ClsHi};
   localparam logic [31:0] RegionSpan [5] = '{HostHi - HostLo, ClsHi - ClsLo, ClsLo - HostHi,
                                              HostLo, 32'h5000_0000};

   logic             clk_i;
   logic             arst_n_i;
   logic [1:0]       req_valid_i;
   logic [1:0]       req_ready_o;
   logic [1:0][31:0] req_addr_i;
   logic [1:0][31:0] req_wdata_i;
   logic [1:0]       req_we_i;
   logic             host_valid_o;
   logic [31:0]      host_addr_o;
   logic [31:0]      host_wdata_o;
   logic             host_we_o;
   logic             host_src_o;
   logic             host_credit_i = 1'b0;
   logic             cls_valid_o;
   logic [31:0]      cls_addr_o;
   logic [31:0]      cls_wdata_o;
   logic             cls_we_o;
   logic             cls_src_o;
   logic             cls_credit_i = 1'b0;
   logic             err_valid_o;
   logic [1:0]       err_code_o;
   logic             err_src_o;
   logic             isolate_i;
   logic             isolated_o;

   integer      seed = 32'h066e86d5;

   // Entry is {code, addr, wdata, we}, queue index is dest * 2 + src
   logic [66:0] exp_q [6][$];
   logic        iso_model    = 1'b1;
   logic        hold_credits = 1'b0;
   int          host_owed;
   int          cls_owed;
   int          host_seen;
   int          cls_seen;
   int          host_mark;
   int          cls_mark;
   int          checks;
   int          errors;
   int          mark_checks;
   int          mark_errors;

   security_island #(
      .CreditDepth ( CreditDepth ),
      .SyncStages  ( SyncStages  )
   ) uut (.*);

   bind security_island security_island_asserts u_asserts (.*);

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   //////////////////////////////////////////////////////////////////////
   // Checking and model
   //////////////////////////////////////////////////////////////////////

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic finish_test(input string name);
      $display("%-14s %0d checks, %0d mismatches", name, checks - mark_checks,
               errors - mark_errors);
      mark_checks = checks;
      mark_errors = errors;
   endtask

   task automatic record_request(input int n, input logic [31:0] addr,
                                 input logic [31:0] wdata, input logic we);
      logic       host_win;
      logic       cls_win;
      logic [1:0] code;
      int         dest;
      host_win = (addr >= HostLo) && (addr < HostHi);
      cls_win  = (addr >= ClsLo) && (addr < ClsHi);
      code     = 2'd0;
      if (host_win && !iso_model) begin
         dest = 0;
      end else if (cls_win) begin
         dest = 1;
      end else begin
         dest = 2;
         code = host_win ? island_pkg::ErrIsolated : island_pkg::ErrDecode;
      end
      exp_q[dest * 2 + n].push_back({code, addr, wdata, we});
   endtask

   task automatic match_output(input int dest, input logic src, input logic [66:0] got);
      logic [66:0] exp;
      string       name;
      int          idx;
      idx  = dest * 2 + int'(src);
      name = (dest == 0) ? "host" : (dest == 1) ? "cls" : "err";
      if (exp_q[idx].size() == 0) begin
         $display("Unexpected %s output for initiator %0d at %0t", name, src, $time);
         errors++;
      end else begin
         exp = exp_q[idx].pop_front();
         if (dest == 2) begin
            check({name, "_code_o"}, got[66:65], exp[66:65]);
         end else begin
            check({name, "_addr_o"}, got[64:33], exp[64:33]);
            check({name, "_wdata_o"}, got[32:1], exp[32:1]);
            check({name, "_we_o"}, got[0], exp[0]);
         end
      end
   endtask

   function automatic int pending();
      int total;
      total = 0;
      for (int i = 0; i < 6; i++) begin
         total += exp_q[i].size();
      end
      return total;
   endfunction

   always @(posedge clk_i) begin
      if (arst_n_i) begin
         for (int n = 0; n < 2; n++) begin
            if (req_valid_i[n] && req_ready_o[n]) begin
               record_request(n, req_addr_i[n], req_wdata_i[n], req_we_i[n]);
            end
         end
         if (host_valid_o) begin
            match_output(0, host_src_o, {2'b00, host_addr_o, host_wdata_o, host_we_o});
            host_seen++;
         end
         if (cls_valid_o) begin
            match_output(1, cls_src_o, {2'b00, cls_addr_o, cls_wdata_o, cls_we_o});
            cls_seen++;
         end
         if (err_valid_o) begin
            match_output(2, err_src_o, {err_code_o, 65'd0});
         end
         host_owed = host_owed + int'(host_valid_o) - int'(host_credit_i);
         cls_owed  = cls_owed + int'(cls_valid_o) - int'(cls_credit_i);
         if (host_owed > CreditDepth || cls_owed > CreditDepth) begin
            $display("A port issued a request without a credit at %0t", $time);
            errors++;
         end
      end
   end

   // Receivers return credits at random, never more than received
   always @(negedge clk_i) begin
      host_credit_i = !hold_credits && (host_owed > 0) && ($random(seed) & 1);
      cls_credit_i  = !hold_credits && (cls_owed > 0) && ($random(seed) & 1);
   end

   //////////////////////////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////////////////////////

   // Mode 0 mixed, 1 outside both windows, 2 inside a window
   function automatic logic [31:0] pick_addr(input int mode);
      logic [31:0] r;
      logic [31:0] base;
      logic [31:0] span;
      int          region;
      r = $random(seed);
      case (mode)
         1:       region = 2 + int'($unsigned($random(seed)) % 3);
         2:       region = int'($unsigned($random(seed)) % 2);
         default: region = int'($unsigned($random(seed)) % 5);
      endcase
      base = RegionBase[region];
      span = RegionSpan[region];
      // Edges of each region now and then
      if (r[31:28] == 4'd0) begin
         return base;
      end else if (r[31:28] == 4'd1) begin
         return base + span - 1;
      end
      return base + (r % span);
   endfunction

   task automatic drive_initiator(input int n, input int count, input int mode);
      for (int i = 0; i < count; i++) begin
         @(negedge clk_i);
         req_valid_i[n] = 1'b1;
         req_addr_i[n]  = pick_addr(mode);
         req_wdata_i[n] = $random(seed);
         req_we_i[n]    = 1'($random(seed));
         @(posedge clk_i);
         while (!req_ready_o[n]) @(posedge clk_i);
         if (($random(seed) & 3) == 0) begin
            @(negedge clk_i);
            req_valid_i[n] = 1'b0;
         end
      end
      @(negedge clk_i);
      req_valid_i[n] = 1'b0;
   endtask

   task automatic run_traffic(input int count, input int mode);
      fork
         drive_initiator(0, count, mode);
         drive_initiator(1, count, mode);
      join
   endtask

   task automatic wait_drained();
      while (pending() != 0 || host_owed != 0 || cls_owed != 0) @(negedge clk_i);
   endtask

   initial begin
      arst_n_i    = 1'b0;
      req_valid_i = '0;
      req_addr_i  = '0;
      req_wdata_i = '0;
      req_we_i    = '0;
      isolate_i   = 1'b1;
      repeat (10) @(posedge clk_i);
      @(negedge clk_i);
      arst_n_i = 1'b1;

      @(negedge clk_i);
      check("isolated_o", isolated_o, 1'b1);
      check("host_valid_o", host_valid_o, 1'b0);
      check("cls_valid_o", cls_valid_o, 1'b0);
      check("err_valid_o", err_valid_o, 1'b0);
      finish_test("reset_state");

      isolate_i = 1'b0;
      while (isolated_o) @(negedge clk_i);
      iso_model = 1'b0;
      run_traffic(60, 0);
      wait_drained();
      finish_test("routing");

      host_mark = host_seen + cls_seen;
      run_traffic(20, 1);
      wait_drained();
      check("port pulses on decode errors", host_seen + cls_seen - host_mark, 0);
      finish_test("decode_errors");

      hold_credits = 1'b1;
      host_mark    = host_seen;
      cls_mark     = cls_seen;
      fork
         run_traffic(12, 2);
         begin
            repeat (50) @(negedge clk_i);
            check("host_valid_o within credit", host_seen - host_mark <= CreditDepth, 1);
            check("cls_valid_o within credit", cls_seen - cls_mark <= CreditDepth, 1);
            hold_credits = 1'b0;
         end
      join
      wait_drained();
      check("requests delivered", host_seen - host_mark + cls_seen - cls_mark, 24);
      finish_test("back_pressure");

      isolate_i = 1'b1;
      while (!isolated_o) @(negedge clk_i);
      iso_model = 1'b1;
      run_traffic(30, 0);
      wait_drained();
      isolate_i = 1'b0;
      while (isolated_o) @(negedge clk_i);
      iso_model = 1'b0;
      host_mark = host_seen;
      run_traffic(20, 2);
      wait_drained();
      check("host_valid_o after release", host_seen > host_mark, 1);
      finish_test("isolation");

      if (uut.u_asserts.assert_failures != 0) begin
         $display("Bound assertions failed %0d times", uut.u_asserts.assert_failures);
         errors += uut.u_asserts.assert_failures;
      end
      $display("Total: %0d checks, %0d mismatches", checks, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   initial begin
      repeat (TimeoutCycles) @(posedge clk_i);
      $display("Timeout after %0d cycles with requests still pending", TimeoutCycles);
      $display("test failed");
      $finish;
   end

endmodule

/* sources.f */
island_pkg.sv
req_arbiter.sv
addr_router.sv
credit_tx.sv
security_island.sv
security_island_asserts.sv
tb_security_island.sv

/* Bender.yml */
package:
  name: security_island

sources:
  # Design
  - island_pkg.sv
  - req_arbiter.sv
  - addr_router.sv
  - credit_tx.sv
  - security_island.sv

  # Verification
  - target: test
    files:
      - security_island_asserts.sv
      - tb_security_island.sv
